// ==== all.f ====
hw/cpu_pkg.sv
hw/ctrl_if.sv
hw/regfile.sv
hw/alu.sv
hw/word_ram.sv
hw/controller.sv
hw/datapath.sv
hw/cpu_top.sv
verif/tb_clock.sv
verif/cpu_asserts.sv
verif/tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_cpu
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
SIM_ARGS ?=

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/tb_cpu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cpu
	import cpu_pkg::*;
();
	typedef struct packed {
		logic [1:0] kind;
		logic [31:0] addr;
		logic [31:0] data;
	} event_t;

	logic clock;
	logic reset;
	logic load_hold;
	logic prog_write;
	logic [imem_addr_bits-1:0] prog_addr;
	logic [31:0] prog_data;
	logic reg_write_strobe;
	logic [4:0] reg_write_addr;
	logic [31:0] reg_write_data;
	logic store_strobe;
	logic [dmem_addr_bits-1:0] store_addr;
	logic [31:0] store_data;

	logic [31:0] prog [256];
	int prog_len;
	logic [31:0] lfsr;
	int cyc;

	// reference machine state
	logic [31:0] m_regs [32];
	logic [31:0] m_dmem [256];
	logic [31:0] m_pc;

	tb_clock u_clock (
		.hold(load_hold),
		.clock(clock),
		.reset(reset)
	);

	cpu_top DUT (
		.clock(clock),
		.reset(reset),
		.prog_write(prog_write),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.reg_write_strobe(reg_write_strobe),
		.reg_write_addr(reg_write_addr),
		.reg_write_data(reg_write_data),
		.store_strobe(store_strobe),
		.store_addr(store_addr),
		.store_data(store_data)
	);

	// cycles since reset release
	always @(posedge clock or posedge reset) begin
		if (reset) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] time %0t %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic [31:0] lfsr_take(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr >> 1;
			if (v[0]) begin
				lfsr = lfsr ^ 32'h80200003;
			end
		end
		return v;
	endfunction

	function automatic logic [31:0] enc_reg(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [4:0] rb, input logic [1:0] sv,
			input logic [7:0] sub);
		return {1'b0, op, rt, ra, rb, sv, sub};
	endfunction

	function automatic logic [31:0] enc_imm(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [14:0] imm);
		return {1'b0, op, rt, ra, imm};
	endfunction

	function automatic logic [31:0] enc_movi(input logic [4:0] rt, input logic [19:0] imm);
		return {1'b0, op_movi, rt, imm};
	endfunction

	function automatic logic [31:0] enc_branch(input logic ne, input logic [4:0] rt,
			input logic [4:0] ra, input logic [13:0] off);
		return {1'b0, op_ty_b, rt, ra, ne, off};
	endfunction

	task automatic put(input logic [31:0] word);
		prog[prog_len] = word;
		prog_len++;
	endtask

	task automatic build_program();
		logic [4:0] alu_subs [5];
		logic [2:0] form;
		logic [1:0] pick;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		alu_subs = '{sub_add, sub_sub, sub_and, sub_or, sub_xor};
		prog_len = 0;
		put(enc_movi(5'd1, 20'h12345));
		put(enc_movi(5'd2, 20'hfff00));
		put(enc_imm(op_addi, 5'd3, 5'd1, 15'h7ffb));
		put(enc_imm(op_swi, 5'd2, 5'd0, 15'd3));
		put(enc_imm(op_addi, 5'd4, 5'd0, 15'd2));
		put(enc_reg(op_ty_ls, 5'd1, 5'd0, 5'd4, 2'd1, sub_sw));
		put(enc_imm(op_lwi, 5'd5, 5'd0, 15'd3));
		put(enc_reg(op_ty_ls, 5'd6, 5'd0, 5'd4, 2'd1, sub_lw));
		// taken beq skips the next word
		put(enc_branch(sub_beq, 5'd2, 5'd5, 14'd4));
		put(enc_imm(op_addi, 5'd7, 5'd0, 15'd1));
		put(enc_branch(sub_bne, 5'd2, 5'd5, 14'd4));
		put(enc_imm(op_addi, 5'd8, 5'd0, 15'd7));
		put(enc_branch(sub_bne, 5'd0, 5'd1, 14'd4));
		put(enc_imm(op_addi, 5'd9, 5'd0, 15'd1));
		put({1'b0, op_j, 1'b0, 24'd4});
		put(enc_imm(op_addi, 5'd10, 5'd0, 15'd1));
		put(enc_reg(op_ty_base, 5'd11, 5'd1, 5'd2, 2'd0, {3'b000, sub_sub}));
		// beq on unequal registers falls through
		put(enc_branch(sub_beq, 5'd0, 5'd1, 14'd4));
		put(enc_imm(op_addi, 5'd14, 5'd0, 15'd3));
		// top immediate bit set so zero extension shows
		put(enc_imm(op_ori, 5'd12, 5'd1, 15'h4000 | 15'(lfsr_take(15))));
		put(enc_imm(op_xori, 5'd13, 5'd2, 15'h4000 | 15'(lfsr_take(15))));
		put(enc_reg(op_ty_base, 5'd15, 5'd1, 5'd5, 2'd0, {3'b000, sub_srli}));
		put(enc_reg(op_ty_base, 5'd16, 5'd2, 5'd9, 2'd0, {3'b000, sub_slli}));
		put(enc_reg(op_ty_base, 5'd17, 5'd1, 5'd13, 2'd0, {3'b000, sub_rotri}));
		for (int i = 0; i < 40; i++) begin
			form = 3'(lfsr_take(3));
			rt = 5'(lfsr_take(5));
			ra = 5'(lfsr_take(5));
			rb = 5'(lfsr_take(5));
			pick = 2'(lfsr_take(2));
			if (form < 3'd5) begin
				put(enc_reg(op_ty_base, rt, ra, rb, 2'd0, {3'b000, alu_subs[form]}));
			end else if (form == 3'd5) begin
				put(enc_reg(op_ty_base, rt, ra, rb, 2'd0,
					{3'b000, (pick == 2'd0) ? sub_srli : (pick == 2'd1) ? sub_slli : sub_rotri}));
			end else if (form == 3'd6) begin
				put(enc_imm((pick == 2'd0) ? op_addi : (pick == 2'd1) ? op_ori : op_xori,
					rt, ra, 15'(lfsr_take(15))));
			end else begin
				put(enc_movi(rt, 20'(lfsr_take(20))));
			end
		end
	endtask

	// executes one instruction on the reference machine
	function automatic event_t model_step();
		event_t ev;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] t;
		logic [31:0] addr;
		logic [31:0] next_pc;
		logic [4:0] s;
		logic eq;
		ins = prog[m_pc[9:2]];
		a = m_regs[ins[19:15]];
		b = m_regs[ins[14:10]];
		t = m_regs[ins[24:20]];
		s = ins[14:10];
		ev = '0;
		next_pc = m_pc + 32'd4;
		case (ins[30:25])
			op_ty_base: begin
				ev.kind = 2'd1;
				case (ins[4:0])
					sub_add: ev.data = a + b;
					sub_sub: ev.data = a - b;
					sub_and: ev.data = a & b;
					sub_or: ev.data = a | b;
					sub_xor: ev.data = a ^ b;
					sub_srli: ev.data = a >> s;
					sub_slli: ev.data = a << s;
					sub_rotri: ev.data = (s == 5'd0) ? a : ((a >> s) | (a << (6'd32 - {1'b0, s})));
					default: ev.kind = 2'd0;
				endcase
			end
			op_addi: ev = {2'd1, 32'd0, a + {{17{ins[14]}}, ins[14:0]}};
			op_ori: ev = {2'd1, 32'd0, a | {17'd0, ins[14:0]}};
			op_xori: ev = {2'd1, 32'd0, a ^ {17'd0, ins[14:0]}};
			op_movi: ev = {2'd1, 32'd0, {{12{ins[19]}}, ins[19:0]}};
			op_lwi, op_swi, op_ty_ls: begin
				if (ins[30:25] == op_ty_ls) begin
					addr = a + (b << ins[9:8]);
				end else begin
					addr = a + {{15{ins[14]}}, ins[14:0], 2'b00};
				end
				if (ins[30:25] == op_lwi || (ins[30:25] == op_ty_ls && ins[7:0] == sub_lw)) begin
					ev = {2'd1, 32'd0, m_dmem[addr[9:2]]};
				end else if (ins[30:25] == op_swi || ins[7:0] == sub_sw) begin
					ev = {2'd2, 24'd0, addr[9:2], t};
					m_dmem[addr[9:2]] = t;
				end
			end
			op_ty_b: begin
				eq = (a == t);
				if (ins[14] ? !eq : eq) begin
					next_pc = m_pc + {{17{ins[13]}}, ins[13:0], 1'b0};
				end
			end
			op_j: next_pc = m_pc + {{7{ins[23]}}, ins[23:0], 1'b0};
			default: ev.kind = 2'd0;
		endcase
		if (ev.kind == 2'd1) begin
			ev.addr = {27'd0, ins[24:20]};
			m_regs[ins[24:20]] = ev.data;
		end
		m_pc = next_pc;
		return ev;
	endfunction

	task automatic expect_event(input event_t ev, input int due);
		int waited;
		logic [1:0] got_kind;
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
			if (waited > 40) begin
				$display("no strobe arrived for the event due at cycle %0d", due);
				abort_run();
			end
		end while (!(reg_write_strobe || store_strobe));
		got_kind = store_strobe ? 2'd2 : 2'd1;
		check("strobe kind", {30'd0, got_kind}, {30'd0, ev.kind});
		check("strobe cycle", cyc, due);
		if (ev.kind == 2'd2) begin
			check("store_addr", {24'd0, store_addr}, ev.addr);
			check("store_data", store_data, ev.data);
		end else begin
			check("reg_write_addr", {27'd0, reg_write_addr}, ev.addr);
			check("reg_write_data", reg_write_data, ev.data);
		end
	endtask

	initial begin
		prog_write = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		load_hold = 1'b1;
		lfsr = 32'hee598b08;
		build_program();
		for (int i = 0; i < prog_len; i++) begin
			@(negedge clock);
			prog_write = 1'b1;
			prog_addr = 8'(i);
			prog_data = prog[i];
		end
		@(negedge clock);
		prog_write = 1'b0;
		load_hold = 1'b0;
	end

	// comparison against the reference machine
	initial begin
		event_t ev;
		int waited;
		int k;
		for (int i = 0; i < 32; i++) begin
			m_regs[i] = '0;
		end
		m_pc = '0;
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
			if (waited > 1000) begin
				$display("reset was never released");
				abort_run();
			end
		end while (reset !== 1'b0);
		k = 0;
		while (int'(m_pc >> 2) < prog_len) begin
			ev = model_step();
			// writeback is the fifth cycle of each instruction, memaccess the fourth
			if (ev.kind != 2'd0) begin
				expect_event(ev, 5 * k + ((ev.kind == 2'd2) ? 3 : 4));
			end
			k++;
		end
		$display("Test passed");
		$finish;
	end
endmodule

`default_nettype wire

// ==== verif/cpu_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_asserts
	import cpu_pkg::*;
(
	input logic clock,
	input logic reset,
	input stage_t state,
	input logic fetch_en,
	input logic decode_en,
	input logic execute_en,
	input logic mem_en,
	input logic writeback_en,
	input logic dm_read,
	input logic dm_write
);
	stage_onehot: assert property (@(posedge clock) disable iff (reset)
		$onehot({fetch_en, decode_en, execute_en, mem_en, writeback_en}))
		else $error("stage enables are not one-hot");

	stage_wrap: assert property (@(posedge clock) disable iff (reset)
		state == st_writeback |=> state == st_fetch)
		else $error("writeback not followed by fetch");

	stage_step: assert property (@(posedge clock) disable iff (reset)
		state != st_writeback |=> int'(state) == int'($past(state)) + 1)
		else $error("stage sequence skipped a state");

	mem_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(dm_read && dm_write))
		else $error("data memory read and write together");

	mem_in_stage: assert property (@(posedge clock) disable iff (reset)
		(dm_read || dm_write) |-> mem_en)
		else $error("data memory access outside memaccess");
endmodule

bind controller cpu_asserts u_cpu_asserts (
	.clock(clock),
	.reset(reset),
	.state(state),
	.fetch_en(ctrl.fetch_en),
	.decode_en(ctrl.decode_en),
	.execute_en(ctrl.execute_en),
	.mem_en(ctrl.mem_en),
	.writeback_en(ctrl.writeback_en),
	.dm_read(ctrl.dm_read),
	.dm_write(ctrl.dm_write)
);

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
	input logic hold,
	output logic clock,
	output logic reset
);
	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// reset covers the program load, then ten more cycles
	initial begin
		reset = 1'b1;
		@(posedge clock);
		while (hold) @(negedge clock);
		repeat (10) @(negedge clock);
		reset = 1'b0;
	end
endmodule

`default_nettype wire

// ==== hw/cpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_top
	import cpu_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic prog_write,
	input logic [imem_addr_bits-1:0] prog_addr,
	input logic [31:0] prog_data,
	output logic reg_write_strobe,
	output logic [4:0] reg_write_addr,
	output logic [31:0] reg_write_data,
	output logic store_strobe,
	output logic [dmem_addr_bits-1:0] store_addr,
	output logic [31:0] store_data
);
	logic [imem_addr_bits-1:0] pc_word;
	logic [imem_addr_bits-1:0] imem_addr;
	logic [31:0] imem_rdata;
	logic [dmem_addr_bits-1:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic [31:0] dmem_rdata;

	ctrl_if ctrl ();

	controller u_controller (
		.clock(clock),
		.reset(reset),
		.ctrl(ctrl.controller)
	);

	datapath u_datapath (
		.clock(clock),
		.reset(reset),
		.ctrl(ctrl.datapath),
		.imem_rdata(imem_rdata),
		.pc_word(pc_word),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_rdata(dmem_rdata),
		.reg_write_addr(reg_write_addr),
		.reg_write_data(reg_write_data)
	);

	// program load port owns the instruction memory while in reset
	assign imem_addr = reset ? prog_addr : pc_word;

	word_ram #(.addr_bits(imem_addr_bits)) u_imem (
		.clock(clock),
		.write(prog_write),
		.addr(imem_addr),
		.wdata(prog_data),
		.rdata(imem_rdata)
	);

	word_ram #(.addr_bits(dmem_addr_bits)) u_dmem (
		.clock(clock),
		.write(ctrl.dm_write),
		.addr(dmem_addr),
		.wdata(dmem_wdata),
		.rdata(dmem_rdata)
	);

	assign reg_write_strobe = ctrl.reg_write;
	assign store_strobe = ctrl.dm_write;
	assign store_addr = dmem_addr;
	assign store_data = dmem_wdata;
endmodule

`default_nettype wire

// ==== hw/datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module datapath
	import cpu_pkg::*;
(
	input logic clock,
	input logic reset,
	ctrl_if.datapath ctrl,
	input logic [31:0] imem_rdata,
	output logic [imem_addr_bits-1:0] pc_word,
	output logic [dmem_addr_bits-1:0] dmem_addr,
	output logic [31:0] dmem_wdata,
	input logic [31:0] dmem_rdata,
	output logic [4:0] reg_write_addr,
	output logic [31:0] reg_write_data
);
	logic [31:0] pc;
	logic [31:0] pc_next;
	logic [31:0] result_q;
	logic [31:0] imm_q;
	logic [31:0] load_q;
	logic [31:0] imm_ext;
	logic [31:0] src2;
	logic [31:0] alu_result;
	logic [31:0] ra_data;
	logic [31:0] rb_data;
	logic [4:0] rb_addr;
	logic alu_zero;
	logic [23:0] imm;

	assign imm = ctrl.instr.imm.value;

	always_comb begin
		case (ctrl.imm_ext_sel)
			ext_sign15: imm_ext = {{17{imm[14]}}, imm[14:0]};
			ext_zero15: imm_ext = {17'd0, imm[14:0]};
			ext_sign20: imm_ext = {{12{imm[19]}}, imm[19:0]};
			default: imm_ext = {{15{imm[14]}}, imm[14:0], 2'b00};
		endcase
	end

	// port b reads rt for branch compares and for store data
	assign rb_addr = (ctrl.mem_en || ctrl.src2_sel == src2_cmp) ?
		ctrl.instr.regs.rt : ctrl.instr.regs.rb;

	always_comb begin
		case (ctrl.src2_sel)
			src2_imm5: src2 = {27'd0, ctrl.instr.regs.rb};
			src2_ext: src2 = imm_ext;
			src2_index: src2 = rb_data << ctrl.instr.regs.sv;
			default: src2 = rb_data;
		endcase
	end

	regfile u_regfile (
		.clock(clock),
		.reset(reset),
		.ra_addr(ctrl.instr.regs.ra),
		.rb_addr(rb_addr),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.write(ctrl.reg_write),
		.write_addr(ctrl.instr.regs.rt),
		.write_data(reg_write_data)
	);

	alu u_alu (
		.op(ctrl.alu_op),
		.a(ra_data),
		.b(src2),
		.result(alu_result),
		.zero(alu_zero)
	);

	always_comb begin
		case (ctrl.pc_sel)
			pc_branch: pc_next = pc + {{17{imm[13]}}, imm[13:0], 1'b0};
			pc_jump: pc_next = pc + {{7{imm[23]}}, imm[23:0], 1'b0};
			default: pc_next = pc + 32'd4;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
			ctrl.instr <= '0;
			ctrl.alu_zero <= 1'b0;
		end else begin
			if (ctrl.decode_en) begin
				ctrl.instr <= imem_rdata;
			end
			if (ctrl.execute_en) begin
				ctrl.alu_zero <= alu_zero;
			end
			if (ctrl.writeback_en) begin
				pc <= pc_next;
			end
		end
	end

	// operand and result registers
	always_ff @(posedge clock) begin
		if (ctrl.execute_en) begin
			result_q <= alu_result;
			imm_q <= imm_ext;
		end
		if (ctrl.dm_read) begin
			load_q <= dmem_rdata;
		end
	end

	// read address goes out in execute so the data is back during memaccess
	assign dmem_addr = ctrl.execute_en ? alu_result[dmem_addr_bits+1:2] :
		result_q[dmem_addr_bits+1:2];
	assign dmem_wdata = rb_data;
	assign pc_word = pc[imem_addr_bits+1:2];

	assign reg_write_addr = ctrl.instr.regs.rt;
	assign reg_write_data = (ctrl.wb_sel == wb_load) ? load_q :
		(ctrl.wb_sel == wb_imm) ? imm_q : result_q;
endmodule

`default_nettype wire

// ==== hw/controller.sv ====
`timescale 1ns/100ps
`default_nettype none

module controller
	import cpu_pkg::*;
(
	input logic clock,
	input logic reset,
	ctrl_if.controller ctrl
);
	stage_t state;
	stage_t state_next;
	logic [5:0] opcode;
	logic [4:0] sub_base;
	logic [7:0] sub_ls;
	logic sub_b;
	logic dec_reg_write;
	logic dec_dm_read;
	logic dec_dm_write;
	logic taken;

	assign opcode = ctrl.instr.regs.opcode;
	assign sub_base = ctrl.instr.regs.sub[4:0];
	assign sub_ls = ctrl.instr.regs.sub;
	assign sub_b = ctrl.instr.imm.value[14];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= st_fetch;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		case (state)
			st_fetch: state_next = st_decode;
			st_decode: state_next = st_execute;
			st_execute: state_next = st_memaccess;
			st_memaccess: state_next = st_writeback;
			default: state_next = st_fetch;
		endcase
	end

	assign ctrl.fetch_en = (state == st_fetch);
	assign ctrl.decode_en = (state == st_decode);
	assign ctrl.execute_en = (state == st_execute);
	assign ctrl.mem_en = (state == st_memaccess);
	assign ctrl.writeback_en = (state == st_writeback);

	// instruction decode, unknown encodings fall through to no write
	always_comb begin
		ctrl.alu_op = alu_add;
		ctrl.src2_sel = src2_reg;
		ctrl.imm_ext_sel = ext_sign15;
		ctrl.wb_sel = wb_alu;
		dec_reg_write = 1'b0;
		dec_dm_read = 1'b0;
		dec_dm_write = 1'b0;
		case (opcode)
			op_ty_base: begin
				dec_reg_write = 1'b1;
				case (sub_base)
					sub_add: ctrl.alu_op = alu_add;
					sub_sub: ctrl.alu_op = alu_sub;
					sub_and: ctrl.alu_op = alu_and;
					sub_or: ctrl.alu_op = alu_or;
					sub_xor: ctrl.alu_op = alu_xor;
					sub_srli: begin
						ctrl.alu_op = alu_srl;
						ctrl.src2_sel = src2_imm5;
					end
					sub_slli: begin
						ctrl.alu_op = alu_sll;
						ctrl.src2_sel = src2_imm5;
					end
					sub_rotri: begin
						ctrl.alu_op = alu_ror;
						ctrl.src2_sel = src2_imm5;
					end
					default: dec_reg_write = 1'b0;
				endcase
			end
			op_addi, op_ori, op_xori: begin
				ctrl.src2_sel = src2_ext;
				dec_reg_write = 1'b1;
				if (opcode == op_addi) begin
					ctrl.alu_op = alu_add;
				end else begin
					ctrl.alu_op = (opcode == op_ori) ? alu_or : alu_xor;
					ctrl.imm_ext_sel = ext_zero15;
				end
			end
			op_movi: begin
				ctrl.src2_sel = src2_ext;
				ctrl.imm_ext_sel = ext_sign20;
				ctrl.wb_sel = wb_imm;
				dec_reg_write = 1'b1;
			end
			op_lwi, op_swi: begin
				ctrl.src2_sel = src2_ext;
				ctrl.imm_ext_sel = ext_word15;
				ctrl.wb_sel = wb_load;
				dec_reg_write = (opcode == op_lwi);
				dec_dm_read = (opcode == op_lwi);
				dec_dm_write = (opcode == op_swi);
			end
			op_ty_ls: begin
				ctrl.src2_sel = src2_index;
				ctrl.wb_sel = wb_load;
				dec_reg_write = (sub_ls == sub_lw);
				dec_dm_read = (sub_ls == sub_lw);
				dec_dm_write = (sub_ls == sub_sw);
			end
			op_ty_b: begin
				// ra minus rt, zero means equal
				ctrl.alu_op = alu_sub;
				ctrl.src2_sel = src2_cmp;
			end
			default: dec_reg_write = 1'b0;
		endcase
	end

	assign ctrl.reg_write = dec_reg_write & ctrl.writeback_en;
	assign ctrl.dm_read = dec_dm_read & ctrl.mem_en;
	assign ctrl.dm_write = dec_dm_write & ctrl.mem_en;

	assign taken = (sub_b == sub_beq) ? ctrl.alu_zero : !ctrl.alu_zero;

	always_comb begin
		case (opcode)
			op_ty_b: ctrl.pc_sel = taken ? pc_branch : pc_seq;
			op_j: ctrl.pc_sel = pc_jump;
			default: ctrl.pc_sel = pc_seq;
		endcase
	end
endmodule

`default_nettype wire

// ==== hw/word_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module word_ram #(
	parameter int addr_bits = 8
) (
	input logic clock,
	input logic write,
	input logic [addr_bits-1:0] addr,
	input logic [31:0] wdata,
	output logic [31:0] rdata
);
	logic [31:0] mem [2**addr_bits];

	// read data registered, old contents on a write
	always_ff @(posedge clock) begin
		if (write) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end
endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu
	import cpu_pkg::*;
(
	input alu_op_t op,
	input logic [31:0] a,
	input logic [31:0] b,
	output logic [31:0] result,
	output logic zero
);
	logic [4:0] shamt;
	logic [63:0] rot;

	assign shamt = b[4:0];
	// rotate as a shift of the doubled word
	assign rot = {a, a} >> shamt;

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or: result = a | b;
			alu_xor: result = a ^ b;
			alu_srl: result = a >> shamt;
			alu_sll: result = a << shamt;
			default: result = rot[31:0];
		endcase
	end

	assign zero = (result == 32'd0);
endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module regfile (
	input logic clock,
	input logic reset,
	input logic [4:0] ra_addr,
	input logic [4:0] rb_addr,
	output logic [31:0] ra_data,
	output logic [31:0] rb_data,
	input logic write,
	input logic [4:0] write_addr,
	input logic [31:0] write_data
);
	logic [31:0] regs [32];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write) begin
			regs[write_addr] <= write_data;
		end
	end

	// asynchronous read
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
endmodule

`default_nettype wire

// ==== hw/ctrl_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface ctrl_if
	import cpu_pkg::*;
();
	logic fetch_en;
	logic decode_en;
	logic execute_en;
	logic mem_en;
	logic writeback_en;
	alu_op_t alu_op;
	src2_sel_t src2_sel;
	imm_ext_sel_t imm_ext_sel;
	wb_sel_t wb_sel;
	pc_sel_t pc_sel;
	logic reg_write;
	logic dm_read;
	logic dm_write;
	instr_u instr;
	logic alu_zero;

	modport controller (
		output fetch_en, decode_en, execute_en, mem_en, writeback_en,
		output alu_op, src2_sel, imm_ext_sel, wb_sel, pc_sel,
		output reg_write, dm_read, dm_write,
		input instr, alu_zero
	);

	modport datapath (
		input fetch_en, decode_en, execute_en, mem_en, writeback_en,
		input alu_op, src2_sel, imm_ext_sel, wb_sel, pc_sel,
		input reg_write, dm_read, dm_write,
		output instr, alu_zero
	);
endinterface

`default_nettype wire

// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// major opcodes, instr[30:25]
	localparam logic [5:0] op_ty_base = 6'b100000;
	localparam logic [5:0] op_addi = 6'b101000;
	localparam logic [5:0] op_ori = 6'b101100;
	localparam logic [5:0] op_xori = 6'b101011;
	localparam logic [5:0] op_movi = 6'b100010;
	localparam logic [5:0] op_lwi = 6'b000010;
	localparam logic [5:0] op_swi = 6'b001010;
	localparam logic [5:0] op_ty_ls = 6'b011100;
	localparam logic [5:0] op_ty_b = 6'b100110;
	localparam logic [5:0] op_j = 6'b100100;

	// base sub-ops, instr[4:0]
	localparam logic [4:0] sub_add = 5'b00000;
	localparam logic [4:0] sub_sub = 5'b00001;
	localparam logic [4:0] sub_and = 5'b00010;
	localparam logic [4:0] sub_xor = 5'b00011;
	localparam logic [4:0] sub_or = 5'b00100;
	localparam logic [4:0] sub_slli = 5'b01000;
	localparam logic [4:0] sub_srli = 5'b01001;
	localparam logic [4:0] sub_rotri = 5'b01011;

	localparam logic [7:0] sub_lw = 8'b00000010;
	localparam logic [7:0] sub_sw = 8'b00001010;

	// branch sub-op sits in instr[14]
	localparam logic sub_beq = 1'b0;
	localparam logic sub_bne = 1'b1;

	localparam int imem_addr_bits = 8;
	localparam int dmem_addr_bits = 8;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_srl, alu_sll, alu_ror
	} alu_op_t;

	typedef enum logic [2:0] {
		src2_reg, src2_imm5, src2_ext, src2_index, src2_cmp
	} src2_sel_t;

	typedef enum logic [1:0] {ext_sign15, ext_zero15, ext_sign20, ext_word15} imm_ext_sel_t;
	typedef enum logic [1:0] {wb_alu, wb_imm, wb_load} wb_sel_t;
	typedef enum logic [1:0] {pc_seq, pc_branch, pc_jump} pc_sel_t;

	typedef enum logic [2:0] {
		st_fetch, st_decode, st_execute, st_memaccess, st_writeback
	} stage_t;

	typedef struct packed {
		logic spare;
		logic [5:0] opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [1:0] sv;
		logic [7:0] sub;
	} instr_reg_view;

	// the 24-bit jump offset overlays rt[3:0], so only the top bit of rt is left here
	typedef struct packed {
		logic spare;
		logic [5:0] opcode;
		logic rt_msb;
		logic [23:0] value;
	} instr_imm_view;

	typedef union packed {
		instr_reg_view regs;
		instr_imm_view imm;
	} instr_u;

endpackage

`default_nettype wire
